//--- src.f
design/ctrl_pkg.sv
design/alu_pkg.sv
design/op_decoder.sv
design/imm_builder.sv
design/reg_port.sv
design/cpu_ctrl.sv
verification/tb_cpu_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the cpu_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cpu_ctrl -o sim_cpu_ctrl
./obj_dir/sim_cpu_ctrl 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
grep -q "Test passed" sim.log

//--- verification/tb_cpu_ctrl.sv
/* random program of single, prefixed and multi-cycle instructions under random cen and op_ok
   gaps; the window reads past the program end are masked by holding op_ok low */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_ctrl;
    import ctrl_pkg::*;
    import alu_pkg::*;

    localparam int N_INSTR     = 80;
    localparam int CYC_PER_INS = 6;     // prefix, exec and fill decisions with their waits
    localparam int STALL_SLACK = 16;    // cen and op_ok are each low a quarter of the time
    localparam int MAX_CYCLES  = N_INSTR * CYC_PER_INS * STALL_SLACK + 200;
    localparam logic [4:0] CK_DST  = 5'b10000;
    localparam logic [4:0] CK_SRC  = 5'b01000;
    localparam logic [4:0] CK_OP   = 5'b00100;
    localparam logic [4:0] CK_SMUX = 5'b00010;
    localparam logic [4:0] CK_IMM  = 5'b00001;

    typedef struct packed {
        logic [7:0]  strb;  // {regs_we, pc_we, flag_we, rfp_we, inc_rfp, dec_rfp}
        logic [4:0]  chk;   // fields that carry a defined value
        logic [7:0]  dst;
        logic [7:0]  src;
        alu_op_t     op;
        logic        smux;
        logic        fill;  // upper immediate bytes arrive in a later decision
        logic [31:0] imm;
    } expect_t;

    logic clk;
    logic rst;
    logic cen;
    logic op_ok;
    op_win_t   op;
    fetch_t    fetched;
    logic      pc_we, inc_rfp, dec_rfp, rfp_we, alu_smux, alu_wait, flag_we;
    imm_t      alu_imm;
    alu_op_t   alu_op;
    we_t       regs_we;
    reg_code_t regs_dst, regs_src;

    logic [7:0] prog [0:1023];
    logic [7:0] mv_codes [0:2] = '{8'h88, 8'h98, 8'ha8};
    logic [7:0] rr_codes [0:4] = '{8'h80, 8'h90, 8'ha0, 8'hc0, 8'he0};
    logic [7:0] ri_codes [0:6] = '{8'h03, 8'hc8, 8'hc9, 8'hca, 8'hcb, 8'hcc, 8'hce};
    expect_t    exp_q [$];
    int         prog_len = 0;
    int         ref_len = 0;
    int         ptr = 0;
    logic       decided = 1'b0;     // first consuming decision seen
    logic       wait_exp = 1'b0;    // next cen cycle must not consume
    logic       wait_seen = 1'b0;   // alu_wait high since the last strobe

    cpu_ctrl dut0 (
        .clk(clk), .rst(rst), .cen(cen), .op_ok(op_ok), .op(op),
        .fetched(fetched), .pc_we(pc_we), .inc_rfp(inc_rfp), .dec_rfp(dec_rfp),
        .rfp_we(rfp_we), .alu_smux(alu_smux), .alu_wait(alu_wait), .flag_we(flag_we),
        .alu_imm(alu_imm), .alu_op(alu_op), .regs_we(regs_we),
        .regs_dst(regs_dst), .regs_src(regs_src)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
            abort_run();
        end
    endtask

    // register code of a 3-bit field, byte regs split into halves
    function automatic logic [7:0] reg_code(input logic [2:0] r, input logic [1:0] sz);
        if (sz == 2'd0) begin
            return {4'he, r[2:1], 1'b0, ~r[0]};
        end
        return {r[2] ? 4'hf : 4'he, r[1:0], 2'b00};
    endfunction

    function automatic logic [2:0] we_for(input logic [1:0] sz);
        return (sz == 2'd0) ? 3'b001 : ((sz == 2'd1) ? 3'b010 : 3'b100);
    endfunction

    function automatic int imm_len(input logic [1:0] sz);
        return (sz == 2'd0) ? 1 : ((sz == 2'd1) ? 2 : 4);
    endfunction

    function automatic logic [31:0] le_bytes(input int at, input int n);
        logic [31:0] v;
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v[8*k +: 8] = prog[at + k];
        end
        return v;
    endfunction

    // expected result of a prefixed instruction at program byte at
    function automatic expect_t predict_prefix(input int at, output int len);
        expect_t e;
        logic [7:0] b, s, rr;
        logic [1:0] sz;
        int p;
        e = '0;
        b = prog[at];
        sz = b[5:4];
        p = b[3] ? 1 : 2;
        rr = b[3] ? reg_code(b[2:0], sz) : prog[at + 1];
        s = prog[at + p];
        len = p + 1;
        e.strb = {we_for(sz), 5'd0};
        e.dst = rr;
        e.src = rr;
        e.chk = CK_DST | CK_SRC | CK_OP | CK_SMUX;
        casez (s)
            8'b1000_1???: begin
                e.dst = reg_code(s[2:0], sz);
                e.op = MOVE;
            end
            8'b1001_1???: begin
                e.src = reg_code(s[2:0], sz);
                e.op = MOVE;
            end
            8'b1010_1???: begin
                e.op = MOVE;
                e.smux = 1'b1;
                e.imm = {29'd0, s[2:0]};
                e.chk = e.chk | CK_IMM;
            end
            8'h06: e.op = CPL;
            8'h03, 8'hc8, 8'hc9, 8'hca, 8'hcb, 8'hcc, 8'hce: begin
                case (s)
                    8'hc8:   e.op = ADD;
                    8'hc9:   e.op = ADC;
                    8'hca:   e.op = SUB;
                    8'hcb:   e.op = SBC;
                    8'hcc:   e.op = AND;
                    8'hce:   e.op = OR;
                    default: e.op = MOVE;
                endcase
                e.smux = 1'b1;
                e.fill = sz != 2'd0;
                e.imm = le_bytes(at + p + 1, imm_len(sz));
                e.chk = e.chk | CK_IMM;
                len = p + 1 + imm_len(sz);
            end
            default: begin // R,r arithmetic writes the short-field register
                case (s[7:4])
                    4'h8:    e.op = ADD;
                    4'h9:    e.op = ADC;
                    4'ha:    e.op = SUB;
                    4'hc:    e.op = AND;
                    default: e.op = OR;
                endcase
                e.dst = reg_code(s[2:0], sz);
            end
        endcase
        return e;
    endfunction

    function automatic expect_t predict(input int at, output int len);
        expect_t e;
        logic [7:0] b;
        logic [1:0] sz;
        e = '0;
        b = prog[at];
        len = 1;
        casez (b)
            8'h12: begin
                e.strb = 8'h08;
                e.op = CCF;
                e.chk = CK_OP;
            end
            8'h17: begin
                e.strb = 8'h04;
                e.imm = {24'd0, prog[at + 1]};
                e.chk = CK_IMM;
                len = 2;
            end
            8'h0c: e.strb = 8'h02;
            8'h0d: e.strb = 8'h01;
            8'h1a, 8'h1b: begin
                len = b[0] ? 4 : 3;
                e.strb = 8'h10;
                e.fill = 1'b1;
                e.imm = le_bytes(at + 1, len - 1);
                e.chk = CK_IMM;
            end
            8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin
                sz = b[6] ? 2'd2 : {1'b0, b[4]};
                len = 1 + imm_len(sz);
                e.strb = {we_for(sz), 5'd0};
                e.dst = reg_code(b[2:0], sz);
                e.op = MOVE;
                e.smux = 1'b1;
                e.fill = sz != 2'd0;
                e.imm = le_bytes(at + 1, len - 1);
                e.chk = CK_DST | CK_OP | CK_SMUX | CK_IMM;
            end
            8'b11??_????: e = predict_prefix(at, len);
            default: ; // NOP, nothing strobes
        endcase
        return e;
    endfunction

    task automatic put_byte(input logic [7:0] b);
        prog[prog_len] = b;
        prog_len++;
    endtask

    task automatic put_imm(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            put_byte(8'($urandom));
        end
    endtask

    task automatic add_instr();
        int cls;
        int sel;
        logic [1:0] sz;
        logic [2:0] r;
        cls = int'($urandom_range(0, 8));
        sel = int'($urandom_range(0, 6));
        sz = 2'($urandom_range(0, 2));
        r = 3'($urandom);
        case (cls)
            0: put_byte(8'h00);
            1: put_byte(8'h12);
            2: begin
                put_byte(8'h17);
                put_imm(1);
            end
            3: put_byte(sel[0] ? 8'h0c : 8'h0d);
            4: begin
                put_byte(8'h20 + {2'b00, sz, 4'h0} + {5'd0, r});
                put_imm(imm_len(sz));
            end
            5: begin
                put_byte(sel[0] ? 8'h1b : 8'h1a);
                put_imm(sel[0] ? 3 : 2);
            end
            default: begin
                if ($urandom_range(0, 1) != 0) begin
                    put_byte({2'b11, sz, 1'b1, 3'($urandom)});
                end else begin
                    put_byte({2'b11, sz, 4'b0111});
                    put_byte(8'($urandom));
                end
                if (cls == 6) begin
                    put_byte((sel % 4 == 3) ? 8'h06 : (mv_codes[sel % 3] | {5'd0, r}));
                end else if (cls == 7) begin
                    put_byte(rr_codes[sel % 5] | {5'd0, r});
                end else begin
                    put_byte(ri_codes[sel]);
                    put_imm(imm_len(sz));
                end
            end
        endcase
    endtask

    task automatic drive_inputs();
        op = {prog[ptr + 3], prog[ptr + 2], prog[ptr + 1], prog[ptr]};
        cen = $urandom_range(0, 3) != 0;
        op_ok = ($urandom_range(0, 3) != 0) && (ptr < prog_len);
    endtask

    initial begin
        expect_t e;
        int at, n, cycles, idle;
        fetch_t f;
        logic c;
        void'($urandom(32'hb403_8f48));
        rst = 1'b1;
        cen = 1'b0;
        op_ok = 1'b0;
        op = '0;
        for (at = 0; at < 1024; at++) begin
            prog[at] = 8'h00;
        end
        repeat (N_INSTR) add_instr();
        at = 0;
        while (at < prog_len) begin
            e = predict(at, n);
            if (e.strb != 8'd0) begin
                exp_q.push_back(e);
            end
            at = at + n;
        end
        ref_len = at;
        cycles = 0;
        idle = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        drive_inputs();
        while (idle < 6) begin
            @(negedge clk);
            f = fetched;
            c = cen;
            @(posedge clk);
            #1;
            ptr = ptr + int'(f);    // memory pointer follows the consumed count
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("timeout: pointer at byte %0d of %0d after %0d cycles",
                         ptr, prog_len, cycles);
                abort_run();
            end
            if (ptr >= prog_len && c) begin
                idle++;
            end
            drive_inputs();
        end
        check_value("program pointer", 32'(ptr), 32'(ref_len));
        if (exp_q.size() == 0) begin
            $display("Test passed");
        end else begin
            $display("%0d expected strobes never appeared", exp_q.size());
            abort_run();
        end
        $finish;
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        expect_t e;
        logic [7:0] strb;
        strb = {regs_we, pc_we, flag_we, rfp_we, inc_rfp, dec_rfp};
        if (rst || !decided) begin
            check_value("strobes", 32'(strb), 32'd0);
            check_value("alu_op", 32'(alu_op), 32'd0);
            check_value("alu_imm", alu_imm, 32'd0);
            check_value("regs_dst", 32'(regs_dst), 32'd0);
            check_value("regs_src", 32'(regs_src), 32'd0);
        end
        if (rst) begin
            check_value("fetched", 32'(fetched), 32'd0);
            wait_exp = 1'b0;
        end else begin
            if (!cen || !op_ok || wait_exp) begin
                check_value("fetched", 32'(fetched), 32'd0);
            end
            if (fetched != 2'd0) begin
                decided = 1'b1;
            end
            if (alu_wait) begin
                wait_seen = 1'b1;
            end
            if (cen && strb != 8'd0) begin
                if (exp_q.size() == 0) begin
                    $display("strobe 0x%0h seen with no instruction pending", strb);
                    abort_run();
                end
                e = exp_q.pop_front();
                check_value("strobes", 32'(strb), 32'(e.strb));
                check_value("alu_wait", 32'(alu_wait), 32'd0);
                check_value("alu_wait before strobe", 32'(wait_seen), 32'(e.fill));
                wait_seen = 1'b0;
                if ((e.chk & CK_DST) != 5'd0) check_value("regs_dst", 32'(regs_dst), 32'(e.dst));
                if ((e.chk & CK_SRC) != 5'd0) check_value("regs_src", 32'(regs_src), 32'(e.src));
                if ((e.chk & CK_OP) != 5'd0) check_value("alu_op", 32'(alu_op), 32'(e.op));
                if ((e.chk & CK_SMUX) != 5'd0) check_value("alu_smux", 32'(alu_smux), 32'(e.smux));
                if ((e.chk & CK_IMM) != 5'd0) check_value("alu_imm", alu_imm, e.imm);
            end
            if (cen) begin
                wait_exp = fetched != 2'd0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cpu_ctrl.sv
/* instruction sequencing controller; op must hold the four bytes at the program pointer,
   and the pointer advances by fetched on every clk edge */
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cen,
    input  wire                    op_ok,
    input  wire ctrl_pkg::op_win_t op,
    output ctrl_pkg::fetch_t       fetched,
    output logic                   pc_we,
    output logic                   inc_rfp,
    output logic                   dec_rfp,
    output logic                   rfp_we,
    output logic                   alu_smux,
    output logic                   alu_wait,
    output logic                   flag_we,
    output ctrl_pkg::imm_t         alu_imm,
    output alu_pkg::alu_op_t       alu_op,
    output ctrl_pkg::we_t          regs_we,
    output ctrl_pkg::reg_code_t    regs_dst,
    output ctrl_pkg::reg_code_t    regs_src
);
    import ctrl_pkg::*;
    import alu_pkg::*;

    reg_code_t nx_dst, nx_src;
    we_t       nx_we, nx_keep_we;
    alu_op_t   nx_alu_op;
    logic      nx_smux, nx_alu_wait, nx_flag_we;
    logic      nx_rfp_we, nx_inc_rfp, nx_dec_rfp;
    logic      imm_load, imm_fill, pc_arm, release_keep;
    imm_t      nx_imm_lo;
    size_t     fill_size;

    op_decoder u_dec (
        .clk, .rst, .cen, .op, .op_ok,
        .cur_dst      (regs_dst),
        .cur_imm      (alu_imm),
        .fetched, .nx_dst, .nx_src, .nx_we, .nx_keep_we, .nx_alu_op,
        .nx_smux, .nx_alu_wait, .nx_flag_we, .nx_rfp_we, .nx_inc_rfp, .nx_dec_rfp,
        .imm_load, .imm_fill, .pc_arm, .nx_imm_lo, .fill_size, .release_keep
    );

    imm_builder u_imm (
        .clk, .rst, .cen, .op,
        .imm_load, .imm_fill, .pc_arm, .nx_imm_lo, .fill_size,
        .alu_imm, .pc_we
    );

    reg_port u_regs (
        .clk, .rst, .cen,
        .nx_dst, .nx_src, .nx_we, .nx_keep_we, .release_keep,
        .regs_dst, .regs_src, .regs_we
    );

    // ALU and RFP controls, strobes last one cen cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_op   <= NOP;
            alu_smux <= 1'b0;
            alu_wait <= 1'b0;
            flag_we  <= 1'b0;
            rfp_we   <= 1'b0;
            inc_rfp  <= 1'b0;
            dec_rfp  <= 1'b0;
        end else if (cen) begin
            alu_op   <= nx_alu_op;
            alu_smux <= nx_smux;
            alu_wait <= nx_alu_wait;
            flag_we  <= nx_flag_we;
            rfp_we   <= nx_rfp_we;
            inc_rfp  <= nx_inc_rfp;
            dec_rfp  <= nx_dec_rfp;
        end
    end

endmodule

`default_nettype wire

//--- design/reg_port.sv
/* register selects and write enable. A write armed by a multi-cycle
   instruction is held until the decoder releases it */
`timescale 1ns/1ps
`default_nettype none

module reg_port (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      cen,
    input  wire ctrl_pkg::reg_code_t nx_dst,
    input  wire ctrl_pkg::reg_code_t nx_src,
    input  wire ctrl_pkg::we_t       nx_we,
    input  wire ctrl_pkg::we_t       nx_keep_we,
    input  wire                      release_keep,
    output ctrl_pkg::reg_code_t      regs_dst,
    output ctrl_pkg::reg_code_t      regs_src,
    output ctrl_pkg::we_t            regs_we
);
    import ctrl_pkg::*;

    we_t keep_q;    // deferred write enable

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs_dst <= '0;
            regs_src <= '0;
            regs_we  <= '0;
            keep_q   <= '0;
        end else if (cen) begin
            regs_dst <= nx_dst;
            regs_src <= nx_src;
            regs_we  <= release_keep ? keep_q : nx_we;
            if (nx_keep_we != '0) begin
                keep_q <= nx_keep_we;
            end else if (release_keep) begin
                keep_q <= '0;
            end
        end
    end

    // the register file writes exactly one width
    a_we_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(regs_we));

endmodule

`default_nettype wire

//--- design/imm_builder.sv
/* alu_imm register; upper bytes arrive one decision after the low byte.
   A jump armed on the first decision strobes pc_we with the completed target */
`timescale 1ns/1ps
`default_nettype none

module imm_builder (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cen,
    input  wire ctrl_pkg::op_win_t op,
    input  wire                    imm_load,
    input  wire                    imm_fill,
    input  wire                    pc_arm,
    input  wire ctrl_pkg::imm_t    nx_imm_lo,
    input  wire ctrl_pkg::size_t   fill_size,
    output ctrl_pkg::imm_t         alu_imm,
    output logic                   pc_we
);
    import ctrl_pkg::*;

    logic armed;    // JP waiting for its upper address bytes

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_imm <= '0;
            armed   <= 1'b0;
            pc_we   <= 1'b0;
        end else if (cen) begin
            pc_we <= imm_fill && armed;
            if (pc_arm) begin
                armed <= 1'b1;
            end else if (imm_fill) begin
                armed <= 1'b0;
            end
            if (imm_load) begin
                alu_imm <= nx_imm_lo;
            end else if (imm_fill) begin
                case (fill_size)
                    SZ_WORD: alu_imm[31:8] <= {16'd0, op[7:0]};
                    SZ_LONG: alu_imm[31:8] <= op[23:0];
                    SZ_JUMP: alu_imm[23:8] <= op[15:0];  // byte 3 stays clear
                    default: ;
                endcase
            end
        end
    end

    // a fill consumes the arm, so a jump never writes the PC twice
    a_pc_single: assert property (@(posedge clk) disable iff (rst)
        (cen && pc_we) |=> !pc_we);

endmodule

`default_nettype wire

//--- design/op_decoder.sv
/* decodes one opcode window per decision; unknown opcodes consume nothing
   and are retried, so an illegal byte stalls the sequencer */
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cen,
    input  wire ctrl_pkg::op_win_t op,
    input  wire                  op_ok,
    input  wire ctrl_pkg::reg_code_t cur_dst,
    input  wire ctrl_pkg::imm_t  cur_imm,
    output ctrl_pkg::fetch_t     fetched,
    output ctrl_pkg::reg_code_t  nx_dst,
    output ctrl_pkg::reg_code_t  nx_src,
    output ctrl_pkg::we_t        nx_we,
    output ctrl_pkg::we_t        nx_keep_we,
    output alu_pkg::alu_op_t     nx_alu_op,
    output logic                 nx_smux,
    output logic                 nx_alu_wait,
    output logic                 nx_flag_we,
    output logic                 nx_rfp_we,
    output logic                 nx_inc_rfp,
    output logic                 nx_dec_rfp,
    output logic                 imm_load,
    output logic                 imm_fill,
    output logic                 pc_arm,
    output ctrl_pkg::imm_t       nx_imm_lo,
    output ctrl_pkg::size_t      fill_size,
    output logic                 release_keep
);
    import ctrl_pkg::*;
    import alu_pkg::*;

    phase_t    phase_q, nx_phase;
    size_t     size_q, nx_size;
    logic      wait_q;      // cen cycle after a consuming decision
    reg_code_t src_q;       // copies of held outputs
    alu_op_t   op_q;
    logic      smux_q;
    logic      decide;

    assign decide    = cen && op_ok && !wait_q;
    assign fill_size = size_q;

    always_comb begin
        nx_phase     = phase_q;
        nx_size      = size_q;
        fetched      = '0;
        nx_dst       = cur_dst;
        nx_src       = src_q;
        nx_we        = '0;
        nx_keep_we   = '0;
        nx_alu_op    = op_q;
        nx_smux      = smux_q;
        nx_flag_we   = 1'b0;
        nx_rfp_we    = 1'b0;
        nx_inc_rfp   = 1'b0;
        nx_dec_rfp   = 1'b0;
        imm_load     = 1'b0;
        imm_fill     = 1'b0;
        pc_arm       = 1'b0;
        nx_imm_lo    = cur_imm;
        release_keep = 1'b0;
        if (decide) begin
            case (phase_q)
                FETCH: begin
                    nx_alu_op = NOP;
                    nx_smux   = 1'b0;
                    casez (op[7:0])
                        8'b0000_0000: fetched = 2'd1;
                        8'b0001_0010: begin
                            nx_flag_we = 1'b1;
                            nx_alu_op  = CCF;
                            fetched    = 2'd1;
                        end
                        8'b0001_0111: begin // LDF
                            nx_rfp_we = 1'b1;
                            imm_load  = 1'b1;
                            nx_imm_lo = {24'd0, op[15:8]};
                            fetched   = 2'd2;
                        end
                        8'b0000_1100: begin
                            nx_inc_rfp = 1'b1;
                            fetched    = 2'd1;
                        end
                        8'b0000_1101: begin
                            nx_dec_rfp = 1'b1;
                            fetched    = 2'd1;
                        end
                        8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin // LD R,#
                            nx_size   = op[6] ? SZ_LONG : (op[4] ? SZ_WORD : SZ_BYTE);
                            nx_dst    = expand_reg(op[2:0], nx_size);
                            imm_load  = 1'b1;
                            nx_imm_lo = {24'd0, op[15:8]};
                            nx_alu_op = MOVE;
                            nx_smux   = 1'b1;
                            fetched   = 2'd2;
                            if (nx_size == SZ_BYTE) begin
                                nx_we = size_to_we(nx_size);
                            end else begin
                                nx_keep_we = size_to_we(nx_size);
                                nx_phase   = FILL_IMM;
                            end
                        end
                        8'b0001_101?: begin // JP #16 / #24
                            imm_load  = 1'b1;
                            nx_imm_lo = {24'd0, op[15:8]};
                            nx_size   = op[0] ? SZ_JUMP : SZ_WORD;
                            pc_arm    = 1'b1;
                            nx_phase  = FILL_IMM;
                            fetched   = 2'd2;
                        end
                        8'b11??_1???: begin // prefix with short register
                            nx_size  = op[5:4];
                            nx_dst   = expand_reg(op[2:0], nx_size);
                            nx_src   = nx_dst;
                            nx_phase = EXEC;
                            fetched  = 2'd1;
                        end
                        8'b11??_0111: begin // prefix with full register byte
                            nx_size  = op[5:4];
                            nx_dst   = op[15:8];
                            nx_src   = op[15:8];
                            nx_phase = EXEC;
                            fetched  = 2'd2;
                        end
                        default: ;
                    endcase
                end
                EXEC: begin
                    nx_phase = FETCH;
                    casez (op[7:0])
                        8'b1000_1???: begin // LD R,r
                            nx_src    = cur_dst;
                            nx_dst    = expand_reg(op[2:0], size_q);
                            nx_alu_op = MOVE;
                            nx_smux   = 1'b0;
                            nx_we     = size_to_we(size_q);
                            fetched   = 2'd1;
                        end
                        8'b1001_1???: begin // LD r,R
                            nx_src    = expand_reg(op[2:0], size_q);
                            nx_alu_op = MOVE;
                            nx_smux   = 1'b0;
                            nx_we     = size_to_we(size_q);
                            fetched   = 2'd1;
                        end
                        8'b1010_1???: begin // LD r,#3
                            imm_load  = 1'b1;
                            nx_imm_lo = {29'd0, op[2:0]};
                            nx_alu_op = MOVE;
                            nx_smux   = 1'b1;
                            nx_we     = size_to_we(size_q);
                            fetched   = 2'd1;
                        end
                        8'b0000_0110: begin
                            nx_alu_op = CPL;
                            nx_smux   = 1'b0;
                            nx_we     = size_to_we(size_q);
                            fetched   = 2'd1;
                        end
                        8'b1000_0???, 8'b1001_0???, 8'b1010_0???,
                        8'b1100_0???, 8'b1110_0???: begin
                            case (op[7:4]) // R,r arithmetic, operands swapped
                                4'h8:    nx_alu_op = ADD;
                                4'h9:    nx_alu_op = ADC;
                                4'ha:    nx_alu_op = SUB;
                                4'hc:    nx_alu_op = AND;
                                default: nx_alu_op = OR;
                            endcase
                            nx_src     = cur_dst;
                            nx_dst     = expand_reg(op[2:0], size_q);
                            nx_smux    = 1'b0;
                            nx_keep_we = size_to_we(size_q);
                            nx_phase   = DUMMY;
                        end
                        8'b0000_0011, 8'b1100_10??, 8'b1100_1100, 8'b1100_1110: begin
                            case (op[7:0]) // LD r,# and r,# arithmetic
                                8'hc8:   nx_alu_op = ADD;
                                8'hc9:   nx_alu_op = ADC;
                                8'hca:   nx_alu_op = SUB;
                                8'hcb:   nx_alu_op = SBC;
                                8'hcc:   nx_alu_op = AND;
                                8'hce:   nx_alu_op = OR;
                                default: nx_alu_op = MOVE;
                            endcase
                            nx_smux  = 1'b1;
                            imm_load = 1'b1;
                            fetched  = 2'd2;
                            if (size_q == SZ_BYTE) begin
                                nx_imm_lo = {24'd0, op[15:8]};
                                nx_we     = size_to_we(size_q);
                            end else begin
                                nx_imm_lo  = {cur_imm[31:8], op[15:8]};
                                nx_keep_we = size_to_we(size_q);
                                nx_phase   = FILL_IMM;
                            end
                        end
                        default: ;
                    endcase
                end
                FILL_IMM: begin
                    imm_fill     = 1'b1;
                    release_keep = 1'b1;
                    nx_phase     = FETCH;
                    case (size_q)
                        SZ_LONG: fetched = 2'd3;
                        SZ_JUMP: fetched = 2'd2;
                        default: fetched = 2'd1;
                    endcase
                end
                DUMMY: begin
                    release_keep = 1'b1;
                    nx_phase     = FETCH;
                    fetched      = 2'd1;
                end
                default: nx_phase = FETCH;
            endcase
        end
        nx_alu_wait = nx_phase == FILL_IMM; // immediate still incomplete
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q <= FETCH;
            size_q  <= SZ_BYTE;
            wait_q  <= 1'b0;
            src_q   <= '0;
            op_q    <= NOP;
            smux_q  <= 1'b0;
        end else if (cen) begin
            phase_q <= nx_phase;
            size_q  <= nx_size;
            wait_q  <= fetched != '0;
            src_q   <= nx_src;
            op_q    <= nx_alu_op;
            smux_q  <= nx_smux;
        end
    end

    // memory pointer only moves on a real decision
    a_fetch_idle: assert property (@(posedge clk) disable iff (rst)
        (!cen || !op_ok || wait_q) |-> fetched == '0);

endmodule

`default_nettype wire

//--- design/alu_pkg.sv
/* ALU operation codes as driven on alu_op; the encoding must match the ALU */
`default_nettype none

package alu_pkg;

    typedef enum logic [5:0] {
        NOP = 6'd0,
        MOVE,       // pass source or immediate
        CCF,
        CPL,
        ADD,
        ADC,
        SUB,
        SBC,
        OR,
        AND
    } alu_op_t;

endpackage

`default_nettype wire

//--- design/ctrl_pkg.sv
/* types shared by the sequencing controller. Register codes follow the current-bank layout,
   and size 3 is only used for the 24-bit jump target */
`default_nettype none

package ctrl_pkg;

    typedef logic [31:0] op_win_t;    // byte 0 in [7:0]
    typedef logic [31:0] imm_t;
    typedef logic [7:0]  reg_code_t;
    typedef logic [1:0]  size_t;
    typedef logic [2:0]  we_t;        // one-hot byte/word/long
    typedef logic [1:0]  fetch_t;

    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_WORD = 2'd1;
    localparam size_t SZ_LONG = 2'd2;
    localparam size_t SZ_JUMP = 2'd3; // jump target, three bytes

    typedef enum logic [1:0] {
        FETCH,
        EXEC,       // second byte after a register prefix
        FILL_IMM,   // upper immediate bytes
        DUMMY       // deferred write of R,r arithmetic
    } phase_t;

    function automatic we_t size_to_we(input size_t sz);
        case (sz)
            SZ_BYTE: return 3'b001;
            SZ_WORD: return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    // byte registers map onto the low/high halves of the current bank
    function automatic reg_code_t expand_reg(input logic [2:0] rr, input size_t sz);
        if (sz == SZ_BYTE) begin
            return {4'he, rr[2:1], 1'b0, ~rr[0]};
        end
        return {rr[2] ? 4'hf : 4'he, rr[1:0], 2'b00};
    endfunction

endpackage

`default_nettype wire
